/* src/rv32_isa_pkg.sv */
`default_nettype none

package rv32_isa_pkg;

    typedef logic [31:0] word_t;

    // Load/store width, encoded as funct3
    typedef enum logic [2:0] {
        LB   = 3'b000,
        LH   = 3'b001,
        LW   = 3'b010,
        LBU  = 3'b100,
        LHU  = 3'b101,
        NONE = 3'b111
    } mem_width_e;

    // Writeback source
    typedef enum logic [1:0] {
        WSEL_LOAD  = 2'd0,
        WSEL_PC4   = 2'd1,
        WSEL_IMM_U = 2'd2,
        WSEL_ALU   = 2'd3
    } wsel_e;

    // Execute to memory pipeline register
    typedef struct packed {
        logic       valid;
        logic       dren;
        logic       dwen;
        mem_width_e width;
        // ALU result, doubles as data address
        word_t      alu_out;
        word_t      rs2_data;
        word_t      pc4;
        word_t      imm_u;
        wsel_e      w_sel;
        logic       reg_write;
        logic [4:0] rd;
        logic       ifence;
    } ex_mem_t;

    // Memory stage exceptions
    typedef struct packed {
        logic mal_l;
        logic mal_s;
        logic fault_l;
        logic fault_s;
    } mem_exc_t;

endpackage

`default_nettype wire

/* src/dbus_pkg.sv */
`default_nettype none

package dbus_pkg;

    // Data RAM geometry and latency
    localparam int RAM_WORDS = 256;
    localparam int RAM_IDX_W = $clog2(RAM_WORDS);
    localparam int RAM_WAIT = 2;
    localparam int RAM_CNT_W = $clog2(RAM_WAIT + 1);

    // Cache flush walk lengths in cycles
    localparam int ICACHE_LINES = 8;
    localparam int DCACHE_LINES = 12;
    localparam int FLUSH_CNT_W = $clog2(DCACHE_LINES + 1);

    typedef struct packed {
        logic        ren;
        logic        wen;
        logic [3:0]  byte_en;
        logic [31:0] addr;
        logic [31:0] wdata;
    } dbus_req_t;

    typedef struct packed {
        logic        busy;
        logic        error;
        logic [31:0] rdata;
    } dbus_rsp_t;

    typedef struct packed {
        logic icache_flush;
        logic dcache_flush;
    } flush_req_t;

    typedef struct packed {
        logic iflush_done;
        logic dflush_done;
    } flush_done_t;

endpackage

`default_nettype wire

/* src/dmem_extender.sv */
`default_nettype none

module dmem_extender (
    input  rv32_isa_pkg::word_t      rdata,
    input  rv32_isa_pkg::mem_width_e width,
    input  logic [1:0]               byte_off,
    output rv32_isa_pkg::word_t      ext_out
);

    logic [7:0]  load_byte;
    logic [15:0] load_half;

    // Little-endian lane select
    assign load_byte = rdata[8*byte_off +: 8];
    assign load_half = rdata[16*byte_off[1] +: 16];

    always_comb begin
        case (width)
            rv32_isa_pkg::LB: begin
                ext_out = {{24{load_byte[7]}}, load_byte};
            end
            rv32_isa_pkg::LBU: begin
                ext_out = {24'h0, load_byte};
            end
            rv32_isa_pkg::LH: begin
                ext_out = {{16{load_half[15]}}, load_half};
            end
            rv32_isa_pkg::LHU: begin
                ext_out = {16'h0, load_half};
            end
            default: begin
                ext_out = rdata;
            end
        endcase
    end

endmodule

`default_nettype wire

/* src/mem_stage.sv */
`default_nettype none

module mem_stage (
    input  logic                   CLK,
    input  logic                   nRST,
    input  rv32_isa_pkg::ex_mem_t  ex_mem,
    input  logic                   suppress_data,
    output dbus_pkg::dbus_req_t    dbus_req,
    input  dbus_pkg::dbus_rsp_t    dbus_rsp,
    output dbus_pkg::flush_req_t   flush_req,
    input  dbus_pkg::flush_done_t  flush_done,
    output rv32_isa_pkg::mem_exc_t exc,
    output logic                   stall,
    output logic                   fw_load,
    output logic                   reg_write,
    output logic [4:0]             rd,
    output rv32_isa_pkg::word_t    reg_wdata
);

    logic                dren;
    logic                dwen;
    logic [1:0]          byte_off;
    logic [3:0]          byte_en;
    logic                mal_addr;
    rv32_isa_pkg::word_t store_data;
    rv32_isa_pkg::word_t load_ext;
    logic                ifence;
    logic                ifence_reg;
    logic                ifence_pulse;
    logic                iflushed;
    logic                dflushed;

    assign dren     = ex_mem.valid & ex_mem.dren;
    assign dwen     = ex_mem.valid & ex_mem.dwen;
    assign byte_off = ex_mem.alu_out[1:0];

    // Byte lanes and alignment from width and offset
    always_comb begin
        case (ex_mem.width)
            rv32_isa_pkg::LB, rv32_isa_pkg::LBU: begin
                byte_en  = 4'b0001 << byte_off;
                mal_addr = 1'b0;
            end
            rv32_isa_pkg::LH, rv32_isa_pkg::LHU: begin
                byte_en  = byte_off[1] ? 4'b1100 : 4'b0011;
                mal_addr = byte_off[0];
            end
            rv32_isa_pkg::LW: begin
                byte_en  = 4'b1111;
                mal_addr = (byte_off != 2'b00);
            end
            default: begin
                byte_en  = 4'b0000;
                mal_addr = 1'b0;
            end
        endcase
    end

    // Replicate narrow stores so every lane carries the data
    always_comb begin
        case (ex_mem.width)
            rv32_isa_pkg::LB, rv32_isa_pkg::LBU: store_data = {4{ex_mem.rs2_data[7:0]}};
            rv32_isa_pkg::LH, rv32_isa_pkg::LHU: store_data = {2{ex_mem.rs2_data[15:0]}};
            default:                             store_data = ex_mem.rs2_data;
        endcase
    end

    // Misaligned accesses never reach the bus
    assign dbus_req.ren     = dren & ~suppress_data & ~mal_addr;
    assign dbus_req.wen     = dwen & ~suppress_data & ~mal_addr;
    assign dbus_req.byte_en = byte_en;
    assign dbus_req.addr    = ex_mem.alu_out;
    assign dbus_req.wdata   = store_data;

    assign exc.mal_l   = dren & mal_addr;
    assign exc.mal_s   = dwen & mal_addr;
    assign exc.fault_l = dbus_req.ren & dbus_rsp.error;
    assign exc.fault_s = dbus_req.wen & dbus_rsp.error;

    dmem_extender u_dmem_extender (
        .rdata    (dbus_rsp.rdata),
        .width    (ex_mem.width),
        .byte_off (byte_off),
        .ext_out  (load_ext)
    );

    // Fence tracking, one flush pulse per new fence
    assign ifence       = ex_mem.valid & ex_mem.ifence;
    assign ifence_pulse = ifence & ~ifence_reg;

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            ifence_reg <= 1'b0;
            iflushed   <= 1'b1;
            dflushed   <= 1'b1;
        end else begin
            // Hold the fence state while the pipeline is frozen
            if (ifence_pulse || !stall) begin
                ifence_reg <= ifence;
            end
            if (ifence_pulse) begin
                iflushed <= 1'b0;
                dflushed <= 1'b0;
            end
            if (flush_done.iflush_done) begin
                iflushed <= 1'b1;
            end
            if (flush_done.dflush_done) begin
                dflushed <= 1'b1;
            end
        end
    end

    assign flush_req.icache_flush = ifence_pulse;
    assign flush_req.dcache_flush = ifence_pulse;

    assign stall = dbus_rsp.busy | (ifence_reg & ~(iflushed & dflushed));

    // Writeback
    assign fw_load   = ex_mem.valid & (ex_mem.dren | ex_mem.dwen);
    assign reg_write = ex_mem.valid & ex_mem.reg_write & ~suppress_data & (exc == '0);
    assign rd        = ex_mem.rd;

    always_comb begin
        case (ex_mem.w_sel)
            rv32_isa_pkg::WSEL_LOAD:  reg_wdata = load_ext;
            rv32_isa_pkg::WSEL_PC4:   reg_wdata = ex_mem.pc4;
            rv32_isa_pkg::WSEL_IMM_U: reg_wdata = ex_mem.imm_u;
            default:                  reg_wdata = ex_mem.alu_out;
        endcase
    end

    // Decode upstream must never issue a combined load and store
    a_no_dual_access: assert property (@(posedge CLK) disable iff (!nRST)
        ex_mem.valid |-> !(ex_mem.dren && ex_mem.dwen))
        else $error("mem_stage: dren and dwen both high");

    // Each cache reports done only for a flush still outstanding
    a_done_when_flushing: assert property (@(posedge CLK) disable iff (!nRST)
        !(flush_done.iflush_done && iflushed) && !(flush_done.dflush_done && dflushed))
        else $error("mem_stage: flush done without an outstanding flush");

endmodule

`default_nettype wire

/* src/data_ram.sv */
`default_nettype none

module data_ram (
    input  logic                CLK,
    input  logic                nRST,
    input  dbus_pkg::dbus_req_t req,
    output dbus_pkg::dbus_rsp_t rsp
);

    logic [31:0]                    mem [dbus_pkg::RAM_WORDS];
    logic [dbus_pkg::RAM_CNT_W-1:0] wait_cnt;
    logic                           completed;
    dbus_pkg::dbus_req_t            last_req;
    logic                           req_v;
    logic                           pending;
    logic                           finish;
    logic                           busy;
    logic                           out_of_range;
    logic [dbus_pkg::RAM_IDX_W-1:0] idx;

    assign req_v        = req.ren | req.wen;
    // An access already served stays served until the request changes or drops
    assign pending      = req_v & ~(completed & (req == last_req));
    assign finish       = pending & (wait_cnt == dbus_pkg::RAM_WAIT);
    assign busy         = pending & ~finish;
    assign out_of_range = (req.addr >= 32'(4 * dbus_pkg::RAM_WORDS));
    assign idx          = req.addr[2 +: dbus_pkg::RAM_IDX_W];

    assign rsp.busy  = busy;
    assign rsp.error = req_v & ~busy & out_of_range;
    assign rsp.rdata = (req.ren && !out_of_range) ? mem[idx] : '0;

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            wait_cnt  <= '0;
            completed <= 1'b0;
        end else if (!req_v) begin
            wait_cnt  <= '0;
            completed <= 1'b0;
        end else if (finish) begin
            wait_cnt  <= '0;
            completed <= 1'b1;
        end else if (pending) begin
            wait_cnt  <= wait_cnt + 1'b1;
            completed <= 1'b0;
        end
    end

    // Storage and completed request snapshot
    always_ff @(posedge CLK) begin
        if (finish) begin
            last_req <= req;
        end
        if (finish && req.wen && !out_of_range) begin
            for (int b = 0; b < 4; b++) begin
                if (req.byte_en[b]) begin
                    mem[idx][8*b +: 8] <= req.wdata[8*b +: 8];
                end
            end
        end
    end

    a_req_stable: assert property (@(posedge CLK) disable iff (!nRST)
        busy |=> $stable(req))
        else $error("data_ram: request changed while busy");

endmodule

`default_nettype wire

/* src/cache_flush_ctrl.sv */
`default_nettype none

module cache_flush_ctrl (
    input  logic                  CLK,
    input  logic                  nRST,
    input  dbus_pkg::flush_req_t  flush_req,
    output dbus_pkg::flush_done_t flush_done
);

    logic [dbus_pkg::FLUSH_CNT_W-1:0] line_cnt [2];
    logic [1:0]                       start;
    logic [1:0]                       done;

    // Walk length per cache, index 0 is the instruction cache
    function automatic logic [dbus_pkg::FLUSH_CNT_W-1:0] walk_len(input int idx);
        walk_len = (idx == 0) ? dbus_pkg::FLUSH_CNT_W'(dbus_pkg::ICACHE_LINES)
                              : dbus_pkg::FLUSH_CNT_W'(dbus_pkg::DCACHE_LINES);
    endfunction

    assign start = {flush_req.dcache_flush, flush_req.icache_flush};

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            for (int i = 0; i < 2; i++) begin
                line_cnt[i] <= '0;
            end
        end else begin
            for (int i = 0; i < 2; i++) begin
                if (start[i]) begin
                    line_cnt[i] <= walk_len(i);
                end else if (line_cnt[i] != '0) begin
                    line_cnt[i] <= line_cnt[i] - 1'b1;
                end
            end
        end
    end

    // Done on the last line of the walk
    assign done[0] = (line_cnt[0] == 1);
    assign done[1] = (line_cnt[1] == 1);

    assign flush_done.iflush_done = done[0];
    assign flush_done.dflush_done = done[1];

    a_no_overlap: assert property (@(posedge CLK) disable iff (!nRST)
        (start != 2'b00) |-> (line_cnt[0] == '0 && line_cnt[1] == '0))
        else $error("cache_flush_ctrl: flush request during a running walk");

endmodule

`default_nettype wire

/* src/mem_subsys_top.sv */
`default_nettype none

module mem_subsys_top (
    input  logic                   CLK,
    input  logic                   nRST,
    input  rv32_isa_pkg::ex_mem_t  ex_mem,
    input  logic                   suppress_data,
    output logic                   reg_write,
    output logic [4:0]             rd,
    output rv32_isa_pkg::word_t    reg_wdata,
    output rv32_isa_pkg::mem_exc_t exc,
    output logic                   stall,
    output logic                   fw_load
);

    dbus_pkg::dbus_req_t   dbus_req;
    dbus_pkg::dbus_rsp_t   dbus_rsp;
    dbus_pkg::flush_req_t  flush_req;
    dbus_pkg::flush_done_t flush_done;

    mem_stage u_mem_stage (
        .CLK           (CLK),
        .nRST          (nRST),
        .ex_mem        (ex_mem),
        .suppress_data (suppress_data),
        .dbus_req      (dbus_req),
        .dbus_rsp      (dbus_rsp),
        .flush_req     (flush_req),
        .flush_done    (flush_done),
        .exc           (exc),
        .stall         (stall),
        .fw_load       (fw_load),
        .reg_write     (reg_write),
        .rd            (rd),
        .reg_wdata     (reg_wdata)
    );

    data_ram u_data_ram (
        .CLK  (CLK),
        .nRST (nRST),
        .req  (dbus_req),
        .rsp  (dbus_rsp)
    );

    cache_flush_ctrl u_cache_flush_ctrl (
        .CLK        (CLK),
        .nRST       (nRST),
        .flush_req  (flush_req),
        .flush_done (flush_done)
    );

endmodule

`default_nettype wire

/* tests/tb_mem_subsys.sv */
`default_nettype none

module tb_mem_subsys;

    localparam int N_INSTR     = 62;
    localparam int N_FENCE     = 2;
    localparam int STALL_MAX   = dbus_pkg::DCACHE_LINES + 3;
    localparam int CYCLE_LIMIT = N_INSTR * (dbus_pkg::RAM_WAIT + 2) + N_FENCE * STALL_MAX
                                 + 16 + 40;

    logic                   CLK;
    logic                   nRST;
    rv32_isa_pkg::ex_mem_t  ex_mem;
    logic                   suppress_data;
    logic                   reg_write;
    logic [4:0]             rd;
    rv32_isa_pkg::word_t    reg_wdata;
    rv32_isa_pkg::mem_exc_t exc;
    logic                   stall;
    logic                   fw_load;

    // Expected response of the instruction being driven
    logic                   chk;
    logic                   fence_chk;
    logic                   exp_we;
    logic [4:0]             exp_rd;
    rv32_isa_pkg::word_t    exp_wdata;
    rv32_isa_pkg::mem_exc_t exp_exc;
    logic                   exp_fw;

    // Byte-wide reference copy of the data RAM
    logic [7:0]             shadow [4*dbus_pkg::RAM_WORDS];
    logic [31:0]            lfsr;
    int                     stall_run;
    int                     cycle_cnt;
    int                     err_cnt;
    int                     pass_cnt;
    int                     fail_cnt;
    int                     test_err;

    initial begin
        CLK = 1'b0;
    end

    always begin
        #5 CLK = ~CLK;
    end

    mem_subsys_top u_mem_subsys_top (
        .CLK           (CLK),
        .nRST          (nRST),
        .ex_mem        (ex_mem),
        .suppress_data (suppress_data),
        .reg_write     (reg_write),
        .rd            (rd),
        .reg_wdata     (reg_wdata),
        .exc           (exc),
        .stall         (stall),
        .fw_load       (fw_load)
    );

    // Length of the current run of stalled cycles
    always @(posedge CLK) begin
        if (stall) begin
            stall_run <= stall_run + 1;
        end else begin
            stall_run <= 0;
        end
    end

    task automatic show_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        err_cnt++;
        $display("[FAIL] %s: got %h, expected %h", name, got, exp);
    endtask

    task automatic note_failure(input string what);
        err_cnt++;
        $display("Check failed: %s", what);
    endtask

    a_reg_write: assert property (@(posedge CLK) disable iff (!nRST)
        (chk && !stall) |-> (reg_write == exp_we))
        else show_mismatch("reg_write", $sampled(reg_write), $sampled(exp_we));

    a_rd: assert property (@(posedge CLK) disable iff (!nRST)
        (chk && !stall && exp_we) |-> (rd == exp_rd))
        else show_mismatch("rd", $sampled(rd), $sampled(exp_rd));

    a_wdata: assert property (@(posedge CLK) disable iff (!nRST)
        (chk && !stall && exp_we) |-> (reg_wdata == exp_wdata))
        else show_mismatch("reg_wdata", $sampled(reg_wdata), $sampled(exp_wdata));

    a_exc: assert property (@(posedge CLK) disable iff (!nRST)
        (chk && !stall) |-> (exc == exp_exc))
        else show_mismatch("exc", $sampled(exc), $sampled(exp_exc));

    a_fw_load: assert property (@(posedge CLK) disable iff (!nRST)
        (chk && !stall) |-> (fw_load == exp_fw))
        else show_mismatch("fw_load", $sampled(fw_load), $sampled(exp_fw));

    a_fence_stall: assert property (@(posedge CLK) disable iff (!nRST)
        (fence_chk && !stall) |=> stall)
        else note_failure("stall did not rise in the cycle after a fence");

    a_stall_bound: assert property (@(posedge CLK) disable iff (!nRST)
        stall |-> (stall_run < STALL_MAX))
        else note_failure("stall stayed high longer than a full cache flush");

    // Galois form, taps of x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    task automatic take_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr[0]};
            lfsr = lfsr_step(lfsr);
        end
    endtask

    function automatic logic misaligned(input rv32_isa_pkg::mem_width_e w,
                                        input logic [1:0] off);
        case (w)
            rv32_isa_pkg::LW:                    misaligned = (off != 2'b00);
            rv32_isa_pkg::LH, rv32_isa_pkg::LHU: misaligned = off[0];
            default:                             misaligned = 1'b0;
        endcase
    endfunction

    // Little-endian load from the reference copy
    function automatic rv32_isa_pkg::word_t load_expect(input logic [31:0] addr,
                                                        input rv32_isa_pkg::mem_width_e w);
        int a;
        a = int'(addr[9:0]);
        case (w)
            rv32_isa_pkg::LB:  load_expect = {{24{shadow[a][7]}}, shadow[a]};
            rv32_isa_pkg::LBU: load_expect = {24'h0, shadow[a]};
            rv32_isa_pkg::LH:  load_expect = {{16{shadow[a+1][7]}}, shadow[a+1], shadow[a]};
            rv32_isa_pkg::LHU: load_expect = {16'h0, shadow[a+1], shadow[a]};
            default:           load_expect = {shadow[a+3], shadow[a+2], shadow[a+1], shadow[a]};
        endcase
    endfunction

    function automatic rv32_isa_pkg::ex_mem_t mem_op(input logic load,
            input rv32_isa_pkg::mem_width_e w, input logic [31:0] addr,
            input logic [31:0] data, input logic [4:0] dst);
        mem_op           = '0;
        mem_op.valid     = 1'b1;
        mem_op.dren      = load;
        mem_op.dwen      = !load;
        mem_op.width     = w;
        mem_op.alu_out   = addr;
        mem_op.rs2_data  = data;
        mem_op.w_sel     = rv32_isa_pkg::WSEL_LOAD;
        mem_op.reg_write = load;
        mem_op.rd        = dst;
    endfunction

    // Distinct values on all three sources so a wrong select shows
    function automatic rv32_isa_pkg::ex_mem_t alu_op(input rv32_isa_pkg::wsel_e sel,
            input logic [31:0] val, input logic [4:0] dst);
        alu_op           = '0;
        alu_op.valid     = 1'b1;
        alu_op.width     = rv32_isa_pkg::NONE;
        alu_op.pc4       = val;
        alu_op.imm_u     = ~val;
        alu_op.alu_out   = {val[15:0], val[31:16]};
        alu_op.w_sel     = sel;
        alu_op.reg_write = 1'b1;
        alu_op.rd        = dst;
    endfunction

    task automatic run_instr(input rv32_isa_pkg::ex_mem_t e, input logic sup);
        logic                   mis;
        logic                   bad;
        logic                   sent;
        rv32_isa_pkg::mem_exc_t x;
        int                     a;
        mis       = (e.dren || e.dwen) && misaligned(e.width, e.alu_out[1:0]);
        bad       = (e.alu_out >= 32'(4 * dbus_pkg::RAM_WORDS));
        sent      = (e.dren || e.dwen) && !mis && !sup;
        x.mal_l   = e.dren && mis;
        x.mal_s   = e.dwen && mis;
        x.fault_l = e.dren && sent && bad;
        x.fault_s = e.dwen && sent && bad;
        ex_mem        <= e;
        suppress_data <= sup;
        chk           <= 1'b1;
        fence_chk     <= e.ifence;
        exp_we        <= e.reg_write && !sup && (x == '0);
        exp_rd        <= e.rd;
        exp_exc       <= x;
        exp_fw        <= e.dren || e.dwen;
        case (e.w_sel)
            rv32_isa_pkg::WSEL_LOAD:  exp_wdata <= load_expect(e.alu_out, e.width);
            rv32_isa_pkg::WSEL_PC4:   exp_wdata <= e.pc4;
            rv32_isa_pkg::WSEL_IMM_U: exp_wdata <= e.imm_u;
            default:                  exp_wdata <= e.alu_out;
        endcase
        // Hold until the stage accepts it
        @(posedge CLK);
        while (stall) begin
            @(posedge CLK);
        end
        if (e.dwen && sent && !bad) begin
            a = int'(e.alu_out[9:0]);
            shadow[a] = e.rs2_data[7:0];
            if (e.width != rv32_isa_pkg::LB && e.width != rv32_isa_pkg::LBU) begin
                shadow[a+1] = e.rs2_data[15:8];
            end
            if (e.width == rv32_isa_pkg::LW) begin
                shadow[a+2] = e.rs2_data[23:16];
                shadow[a+3] = e.rs2_data[31:24];
            end
        end
    endtask

    task automatic end_test(input string name);
        ex_mem        <= '0;
        suppress_data <= 1'b0;
        chk           <= 1'b0;
        fence_chk     <= 1'b0;
        @(posedge CLK);
        if (err_cnt == test_err) begin
            pass_cnt++;
            $display("Test %-24s ok", name);
        end else begin
            fail_cnt++;
            $display("Test %-24s failed with %0d errors", name, err_cnt - test_err);
        end
        test_err = err_cnt;
    endtask

    initial begin
        cycle_cnt = 0;
        while (cycle_cnt < CYCLE_LIMIT) begin
            @(posedge CLK);
            cycle_cnt++;
        end
        $display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
        $display("Result: FAILED");
        $finish;
    end

    initial begin
        logic [31:0]           addr;
        logic [31:0]           data;
        logic [31:0]           dst;
        logic [31:0]           off;
        rv32_isa_pkg::ex_mem_t e;
        lfsr          = 32'hbac3;
        err_cnt       = 0;
        pass_cnt      = 0;
        fail_cnt      = 0;
        test_err      = 0;
        stall_run     = 0;
        nRST          = 1'b0;
        ex_mem        = '0;
        suppress_data = 1'b0;
        chk           = 1'b0;
        fence_chk     = 1'b0;
        exp_we        = 1'b0;
        exp_rd        = '0;
        exp_wdata     = '0;
        exp_exc       = '0;
        exp_fw        = 1'b0;
        repeat (16) @(posedge CLK);
        nRST <= 1'b1;

        repeat (4) begin
            take_bits(8, addr);
            take_bits(32, data);
            take_bits(5, dst);
            run_instr(mem_op(1'b0, rv32_isa_pkg::LW, addr << 2, data, 5'd0), 1'b0);
            run_instr(mem_op(1'b1, rv32_isa_pkg::LW, addr << 2, 32'h0, dst[4:0]), 1'b0);
        end
        end_test("word store and load");

        repeat (2) begin
            take_bits(8, addr);
            addr = addr << 2;
            take_bits(32, data);
            run_instr(mem_op(1'b0, rv32_isa_pkg::LW, addr, data, 5'd0), 1'b0);
            for (int k = 0; k < 4; k++) begin
                take_bits(8, data);
                take_bits(5, dst);
                run_instr(mem_op(1'b0, rv32_isa_pkg::LB, addr + k, data, 5'd0), 1'b0);
                run_instr(mem_op(1'b1, rv32_isa_pkg::LB, addr + k, 32'h0, dst[4:0]), 1'b0);
                run_instr(mem_op(1'b1, rv32_isa_pkg::LBU, addr + k, 32'h0, dst[4:0]), 1'b0);
            end
            for (int k = 0; k < 4; k += 2) begin
                take_bits(16, data);
                take_bits(5, dst);
                run_instr(mem_op(1'b0, rv32_isa_pkg::LH, addr + k, data, 5'd0), 1'b0);
                run_instr(mem_op(1'b1, rv32_isa_pkg::LH, addr + k, 32'h0, dst[4:0]), 1'b0);
                run_instr(mem_op(1'b1, rv32_isa_pkg::LHU, addr + k, 32'h0, dst[4:0]), 1'b0);
            end
        end
        end_test("byte and halfword access");

        take_bits(8, addr);
        addr = addr << 2;
        take_bits(32, data);
        take_bits(2, off);
        off = (off == 0) ? 32'd1 : off;
        run_instr(mem_op(1'b0, rv32_isa_pkg::LW, addr, data, 5'd0), 1'b0);
        run_instr(mem_op(1'b0, rv32_isa_pkg::LW, addr + off, ~data, 5'd0), 1'b0);
        run_instr(mem_op(1'b0, rv32_isa_pkg::LH, addr + 1, ~data, 5'd0), 1'b0);
        run_instr(mem_op(1'b1, rv32_isa_pkg::LW, addr + off, 32'h0, 5'd7), 1'b0);
        run_instr(mem_op(1'b1, rv32_isa_pkg::LHU, addr + 3, 32'h0, 5'd8), 1'b0);
        run_instr(mem_op(1'b1, rv32_isa_pkg::LW, addr, 32'h0, 5'd9), 1'b0);
        end_test("misaligned access");

        take_bits(8, addr);
        addr = 32'(4 * dbus_pkg::RAM_WORDS) + (addr << 2);
        run_instr(mem_op(1'b0, rv32_isa_pkg::LW, addr, data, 5'd0), 1'b0);
        run_instr(mem_op(1'b1, rv32_isa_pkg::LW, addr, 32'h0, 5'd10), 1'b0);
        end_test("out of range access");

        repeat (N_FENCE) begin
            e           = alu_op(rv32_isa_pkg::WSEL_ALU, 32'h0, 5'd0);
            e.reg_write = 1'b0;
            e.ifence    = 1'b1;
            run_instr(e, 1'b0);
            take_bits(32, data);
            run_instr(alu_op(rv32_isa_pkg::WSEL_ALU, data, 5'd11), 1'b0);
        end
        end_test("fence flush");

        take_bits(32, data);
        run_instr(alu_op(rv32_isa_pkg::WSEL_PC4, data, 5'd1), 1'b0);
        run_instr(alu_op(rv32_isa_pkg::WSEL_IMM_U, data, 5'd2), 1'b0);
        run_instr(alu_op(rv32_isa_pkg::WSEL_ALU, data, 5'd3), 1'b0);
        run_instr(alu_op(rv32_isa_pkg::WSEL_ALU, data, 5'd4), 1'b1);
        end_test("non-memory writeback");

        $display("Tests passed: %0d, failed: %0d, check errors: %0d",
                 pass_cnt, fail_cnt, err_cnt);
        if (fail_cnt == 0 && err_cnt == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* flist.f */
src/rv32_isa_pkg.sv
src/dbus_pkg.sv
src/dmem_extender.sv
src/mem_stage.sv
src/data_ram.sv
src/cache_flush_ctrl.sv
src/mem_subsys_top.sv
tests/tb_mem_subsys.sv

/* Bender.yml */
package:
  name: mem_subsys

sources:
  - src/rv32_isa_pkg.sv
  - src/dbus_pkg.sv
  - src/dmem_extender.sv
  - src/mem_stage.sv
  - src/data_ram.sv
  - src/cache_flush_ctrl.sv
  - src/mem_subsys_top.sv
  - target: test
    files:
      - tests/tb_mem_subsys.sv
